// ==== verilog/mk14_defines.svh ====
// MK14 display constants

`ifndef MK14_DEFINES_SVH
`define MK14_DEFINES_SVH

// memory map.
`define MK14_ADDR_W 9
`define MK14_SEG7_BASE 'h100
`define MK14_SEG7_COUNT 8

// refresh timer, kept short so simulation sees many frames.
`define MK14_REFRESH_CYCLES 600

// clock cycles per half period of the serial clock.
`define MK14_BIT_DIV 2

`endif

// ==== verilog/mk14_mem_pkg.sv ====
// Memory side types

`include "mk14_defines.svh"

package mk14_mem_pkg;

	// byte address into the trainer memory.
	typedef logic [`MK14_ADDR_W-1:0] addr_t;

	// one memory byte.
	typedef logic [7:0] byte_t;

endpackage

// ==== verilog/tm1638_pkg.sv ====
// TM1638 protocol types

package tm1638_pkg;

	typedef logic [7:0] cmd_t;	// one byte on the serial stream.
	typedef logic [2:0] bright_t;	// display brightness.

	// ########################################
	// command bytes
	// ########################################
	localparam cmd_t CMD_DATA_AUTO = 8'h40;	// write data, auto increment.
	localparam cmd_t CMD_ADDR0 = 8'hC0;	// start at display address 0.
	localparam cmd_t CMD_CTRL_ON = 8'h88;	// display on, brightness in bits 2:0.

	// frame sequencer states.
	typedef enum logic [2:0] {
		S_IDLE,
		S_SET_MODE,
		S_SET_ADDR,
		S_FETCH,
		S_SEND_DIGIT,
		S_SEND_LED,
		S_CTRL
	} scan_state_t;

endpackage

// ==== verilog/bram_dp.sv ====
// Dual-port byte memory

`timescale 1ns/1ns

`include "mk14_defines.svh"

module bram_dp (
	input logic clk,

	// host port, write and read.
	input logic i_a_we,
	input mk14_mem_pkg::addr_t i_a_addr,
	input mk14_mem_pkg::byte_t i_a_wdata,
	output mk14_mem_pkg::byte_t o_a_rdata,

	// scanner port, read only.
	input mk14_mem_pkg::addr_t i_b_addr,
	output mk14_mem_pkg::byte_t o_b_rdata
);

localparam int DEPTH = 2 ** `MK14_ADDR_W;

mk14_mem_pkg::byte_t mem [0:DEPTH-1];

// ########################################
// port A
// ########################################
always_ff @(posedge clk) begin
	if (i_a_we) begin
		mem[i_a_addr] <= i_a_wdata;
	end
	o_a_rdata <= mem[i_a_addr];	// old data on a write.
end

// ########################################
// port B
// ########################################
always_ff @(posedge clk) begin
	o_b_rdata <= mem[i_b_addr];
end

endmodule

// ==== verilog/display_scanner.sv ====
// Display refresh scanner

`timescale 1ns/1ns

`include "mk14_defines.svh"

module display_scanner (
	input logic clk,
	input logic rst_n,
	input tm1638_pkg::bright_t i_brightness,

	output mk14_mem_pkg::addr_t o_rd_addr,
	input mk14_mem_pkg::byte_t i_rd_data,

	output tm1638_pkg::cmd_t o_tx_byte,
	output logic o_tx_valid,
	output logic o_tx_last,
	input logic i_tx_ready
);

localparam int REF_W = $clog2(`MK14_REFRESH_CYCLES);
localparam int IDX_W = $clog2(`MK14_SEG7_COUNT);

logic [REF_W-1:0] refresh_cnt;
logic tick;
logic xfer;
logic [IDX_W-1:0] idx;
tm1638_pkg::scan_state_t state;

assign tick = (refresh_cnt == '0);
assign xfer = o_tx_valid & i_tx_ready;

// address leads the fetch state by at least one cycle.
assign o_rd_addr = mk14_mem_pkg::addr_t'(`MK14_SEG7_BASE) + mk14_mem_pkg::addr_t'(idx);

// ########################################
// refresh timer
// ########################################
always_ff @(posedge clk) begin
	if (!rst_n || tick) begin
		refresh_cnt <= REF_W'(`MK14_REFRESH_CYCLES - 1);
	end else begin
		refresh_cnt <= refresh_cnt - 1'b1;
	end
end

// ########################################
// frame sequencer
// ########################################
always_ff @(posedge clk) begin
	if (!rst_n) begin
		state <= tm1638_pkg::S_IDLE;
		o_tx_valid <= 1'b0;
		o_tx_last <= 1'b0;
		idx <= '0;
	end else begin
		case (state)
		tm1638_pkg::S_IDLE: if (tick) begin	// busy ticks are dropped.
			o_tx_byte <= tm1638_pkg::CMD_DATA_AUTO;
			o_tx_last <= 1'b1;
			o_tx_valid <= 1'b1;
			state <= tm1638_pkg::S_SET_MODE;
		end
		tm1638_pkg::S_SET_MODE: if (xfer) begin
			o_tx_byte <= tm1638_pkg::CMD_ADDR0;
			o_tx_last <= 1'b0;
			idx <= '0;
			state <= tm1638_pkg::S_SET_ADDR;
		end
		tm1638_pkg::S_SET_ADDR: if (xfer) begin
			o_tx_valid <= 1'b0;
			state <= tm1638_pkg::S_FETCH;
		end
		tm1638_pkg::S_FETCH: begin
			o_tx_byte <= i_rd_data;	// segment pattern.
			o_tx_valid <= 1'b1;
			state <= tm1638_pkg::S_SEND_DIGIT;
		end
		tm1638_pkg::S_SEND_DIGIT: if (xfer) begin
			o_tx_byte <= 8'h00;	// LEDs stay dark.
			o_tx_last <= (idx == IDX_W'(`MK14_SEG7_COUNT - 1));
			idx <= idx + 1'b1;
			state <= tm1638_pkg::S_SEND_LED;
		end
		tm1638_pkg::S_SEND_LED: if (xfer) begin
			if (o_tx_last) begin
				o_tx_byte <= tm1638_pkg::CMD_CTRL_ON | tm1638_pkg::cmd_t'(i_brightness);
				state <= tm1638_pkg::S_CTRL;
			end else begin
				o_tx_valid <= 1'b0;
				state <= tm1638_pkg::S_FETCH;
			end
		end
		tm1638_pkg::S_CTRL: if (xfer) begin
			o_tx_valid <= 1'b0;
			o_tx_last <= 1'b0;
			state <= tm1638_pkg::S_IDLE;
		end
		default: state <= tm1638_pkg::S_IDLE;
		endcase
	end
end

endmodule

// ==== verilog/tm1638_tx.sv ====
// TM1638 serial transmitter

`timescale 1ns/1ns

`include "mk14_defines.svh"

module tm1638_tx #(
	parameter int HALF_BIT = `MK14_BIT_DIV	// cycles per serial clock half period.
) (
	input logic clk,
	input logic rst_n,

	input tm1638_pkg::cmd_t i_byte,
	input logic i_valid,
	input logic i_last,
	output logic o_ready,

	output logic o_tm1638_clk,
	output logic o_tm1638_stb,
	output logic o_tm1638_dio
);

localparam int DIV_W = $clog2(HALF_BIT + 1);
localparam int GAP = 2 * HALF_BIT;	// minimum strobe high time.
localparam int GAP_W = $clog2(GAP);

tm1638_pkg::cmd_t sh;
logic busy;
logic last_q;
logic phase_hi;
logic [2:0] bit_cnt;
logic [DIV_W-1:0] div_cnt;
logic [GAP_W-1:0] gap_cnt;
logic final_edge;

assign o_ready = ~busy & ~last_q & (gap_cnt == '0);

// the shift register empties one cycle early, so that cycle
// is the last of the high phase and back to back bytes have no gap.
assign final_edge = (bit_cnt == 3'd7) &&
	((phase_hi && div_cnt == DIV_W'(1)) || (!phase_hi && div_cnt == '0 && HALF_BIT == 1));

// ########################################
// shifter and pin control
// ########################################
always_ff @(posedge clk) begin
	if (!rst_n) begin
		busy <= 1'b0;
		last_q <= 1'b0;
		phase_hi <= 1'b1;
		bit_cnt <= '0;
		div_cnt <= '0;
		gap_cnt <= '0;
		o_tm1638_clk <= 1'b1;
		o_tm1638_stb <= 1'b1;
		o_tm1638_dio <= 1'b1;
	end else if (busy) begin
		if (div_cnt != '0) begin
			div_cnt <= div_cnt - 1'b1;
		end else begin
			div_cnt <= DIV_W'(HALF_BIT - 1);
			if (!phase_hi) begin
				phase_hi <= 1'b1;
				o_tm1638_clk <= 1'b1;	// display samples here.
			end else begin
				phase_hi <= 1'b0;
				o_tm1638_clk <= 1'b0;
				bit_cnt <= bit_cnt + 1'b1;
				sh <= sh >> 1;
				o_tm1638_dio <= sh[1];	// next bit, LSB first.
			end
		end
		if (final_edge) begin
			busy <= 1'b0;
		end
	end else if (last_q) begin
		// group done, strobe goes high.
		last_q <= 1'b0;
		o_tm1638_stb <= 1'b1;
		gap_cnt <= GAP_W'(GAP - 1);
	end else if (gap_cnt != '0) begin
		gap_cnt <= gap_cnt - 1'b1;
	end else if (i_valid) begin
		sh <= i_byte;
		last_q <= i_last;
		busy <= 1'b1;
		phase_hi <= 1'b0;
		bit_cnt <= '0;
		div_cnt <= DIV_W'(HALF_BIT - 1);
		o_tm1638_stb <= 1'b0;
		o_tm1638_clk <= 1'b0;
		o_tm1638_dio <= i_byte[0];
	end
end

endmodule

// ==== verilog/mk14_display_top.sv ====
// MK14 display subsystem

`timescale 1ns/1ns

`include "mk14_defines.svh"

module mk14_display_top (
	input logic clk,
	input logic rst_n,

	// host memory port.
	input logic i_wr_en,
	input mk14_mem_pkg::addr_t i_wr_addr,
	input mk14_mem_pkg::byte_t i_wr_data,
	output mk14_mem_pkg::byte_t o_rd_data,

	input tm1638_pkg::bright_t i_brightness,

	// LED&KEY board pins.
	output logic o_ledkey_clk,
	output logic o_ledkey_stb,
	output logic o_ledkey_dio
);

mk14_mem_pkg::addr_t scan_addr;
mk14_mem_pkg::byte_t scan_data;
tm1638_pkg::cmd_t tx_byte;
logic tx_valid;
logic tx_last;
logic tx_ready;

bram_dp u_mem (
	.clk(clk),
	.i_a_we(i_wr_en),
	.i_a_addr(i_wr_addr),
	.i_a_wdata(i_wr_data),
	.o_a_rdata(o_rd_data),
	.i_b_addr(scan_addr),
	.o_b_rdata(scan_data)
);

display_scanner u_scan (
	.clk(clk),
	.rst_n(rst_n),
	.i_brightness(i_brightness),
	.o_rd_addr(scan_addr),
	.i_rd_data(scan_data),
	.o_tx_byte(tx_byte),
	.o_tx_valid(tx_valid),
	.o_tx_last(tx_last),
	.i_tx_ready(tx_ready)
);

tm1638_tx #(.HALF_BIT(`MK14_BIT_DIV)) u_tx (
	.clk(clk),
	.rst_n(rst_n),
	.i_byte(tx_byte),
	.i_valid(tx_valid),
	.i_last(tx_last),
	.o_ready(tx_ready),
	.o_tm1638_clk(o_ledkey_clk),
	.o_tm1638_stb(o_ledkey_stb),
	.o_tm1638_dio(o_ledkey_dio)
);

endmodule

// ==== verif/mk14_display_assert.sv ====
// TM1638 transmitter assertions

`timescale 1ns/1ns

module mk14_display_assert (
	input logic clk,
	input logic rst_n,
	input logic [7:0] i_byte,
	input logic i_valid,
	input logic i_last,
	input logic o_ready,
	input logic o_tm1638_clk,
	input logic o_tm1638_stb
);

int fail_cnt = 0;	// assertion failures so far.
logic clk_q;
logic [2:0] rise_cnt;	// serial clock rises in this group, mod 8.

always_ff @(posedge clk) begin
	clk_q <= o_tm1638_clk;
	if (!rst_n || o_tm1638_stb) begin
		rise_cnt <= '0;
	end else if (o_tm1638_clk && !clk_q) begin
		rise_cnt <= rise_cnt + 1'b1;
	end
end

// a stalled byte must not move.
a_stream_hold: assert property (@(posedge clk) disable iff (!rst_n)
	i_valid && !o_ready |=> i_valid && $stable(i_byte) && $stable(i_last))
	else begin
		fail_cnt++;
		$error("stream changed while stalled");
	end

// strobe only rises on a byte boundary.
a_stb_rise: assert property (@(posedge clk) disable iff (!rst_n)
	$rose(o_tm1638_stb) |-> rise_cnt == '0)
	else begin
		fail_cnt++;
		$error("strobe rose in the middle of a byte");
	end

// serial clock only moves inside a group.
a_clk_in_group: assert property (@(posedge clk) disable iff (!rst_n)
	$changed(o_tm1638_clk) |-> !o_tm1638_stb)
	else begin
		fail_cnt++;
		$error("serial clock toggled with strobe high");
	end

endmodule

bind tm1638_tx mk14_display_assert u_assert (
	.clk(clk),
	.rst_n(rst_n),
	.i_byte(i_byte),
	.i_valid(i_valid),
	.i_last(i_last),
	.o_ready(o_ready),
	.o_tm1638_clk(o_tm1638_clk),
	.o_tm1638_stb(o_tm1638_stb)
);

// ==== verif/mk14_display_tb.sv ====
// MK14 display testbench

`timescale 1ns/1ns

`include "mk14_defines.svh"

module mk14_display_tb;

localparam int FRAME_CYCLES = `MK14_REFRESH_CYCLES + 19 * 16 * `MK14_BIT_DIV;

logic clk = 1'b0;
logic rst_n;
logic wr_en;
mk14_mem_pkg::addr_t wr_addr;
mk14_mem_pkg::byte_t wr_data;
mk14_mem_pkg::byte_t rd_data;
tm1638_pkg::bright_t brightness;
logic led_clk;
logic led_stb;
logic led_dio;

logic [7:0] frame_buf [0:18];	// one decoded frame.
time done_start = 0;
event frame_ev;
int nframes = 0;
logic counted = 1'b0;

mk14_display_top UUT (
	.clk(clk),
	.rst_n(rst_n),
	.i_wr_en(wr_en),
	.i_wr_addr(wr_addr),
	.i_wr_data(wr_data),
	.o_rd_data(rd_data),
	.i_brightness(brightness),
	.o_ledkey_clk(led_clk),
	.o_ledkey_stb(led_stb),
	.o_ledkey_dio(led_dio)
);

always #20 clk = ~clk;

task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
	if (actual !== expected) begin
		$display("[FAIL] %0t ns: %s, got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
		$display("** FAIL **");
		$fatal(1, "mismatch");
	end
endtask

task automatic write_byte(input int addr, input int data);
	@(posedge clk);
	#2;
	wr_en = 1'b1;
	wr_addr = mk14_mem_pkg::addr_t'(addr);
	wr_data = mk14_mem_pkg::byte_t'(data);
	@(posedge clk);
	#2;
	wr_en = 1'b0;	// address stays, so the read starts here.
endtask

task automatic probe_random();
	int addr;
	int data;
	addr = int'($urandom % 512);
	if (addr >= `MK14_SEG7_BASE && addr < `MK14_SEG7_BASE + `MK14_SEG7_COUNT)
		addr += `MK14_SEG7_COUNT;
	data = int'($urandom % 256);
	write_byte(addr, data);
	@(posedge clk);
	#2;
	check(32'(rd_data), data, $sformatf("read back at 0x%0h", addr));
endtask

// ########################################
// serial decoder
// ########################################
initial begin
	logic [7:0] sh;
	int pos;
	int grp;
	int nbits;
	int grp_start;
	time frame_start;
	sh = '0;
	pos = 0;
	grp = 0;
	frame_start = 0;
	wait (rst_n === 1'b1);
	forever begin
		@(negedge led_stb);
		grp_start = pos;
		nbits = 0;
		if (grp == 0) frame_start = $time;
		@(posedge led_clk or posedge led_stb);
		while (led_stb === 1'b0) begin
			sh = {led_dio, sh[7:1]};	// LSB first.
			nbits++;
			if (nbits == 8) begin
				if (pos < 19) frame_buf[pos] = sh;
				pos++;
				nbits = 0;
			end
			@(posedge led_clk or posedge led_stb);
		end
		check(nbits, 0, "partial byte at strobe rise");
		check(pos - grp_start, (grp == 1) ? 17 : 1, $sformatf("length of group %0d", grp));
		if (grp == 0) check(32'(frame_buf[0]), 'h40, "mode command");
		if (grp == 2) check(32'(frame_buf[18] & 8'hF8), 'h88, "control command");
		if (grp == 1) begin
			check(32'(frame_buf[1]), 'hC0, "address command");
			for (int k = 3; k <= 17; k += 2) check(32'(frame_buf[k]), 0, "LED byte");
		end
		grp++;
		if (grp == 3) begin
			grp = 0;
			pos = 0;
			done_start = frame_start;
			->frame_ev;
		end
	end
end

// ########################################
// watchdog
// ########################################
initial begin
	wait (counted);
	#((nframes + 2) * FRAME_CYCLES * 40);
	$display("watchdog timeout, the expected frames never arrived");
	$display("** FAIL **");
	$fatal(1, "timeout");
end

initial begin
	int fd;
	int code;
	int a;
	int d;
	int exp_d [0:7];
	int exp_b;
	time t_mark;
	string tag;
	string line;
	rst_n = 1'b0;
	wr_en = 1'b0;
	wr_addr = '0;
	wr_data = '0;
	brightness = '0;
	a = int'($urandom(83197));
	fd = $fopen("verif/mk14_display_testdata.txt", "r");
	if (fd == 0) begin
		$display("cannot open the test data file");
		$display("** FAIL **");
		$fatal(1, "no data");
	end else begin
		while ($fscanf(fd, "%s", tag) == 1) if (tag == "F") nframes++;
		$fclose(fd);
		counted = 1'b1;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check(32'({led_stb, led_clk, led_dio}), 'h7, "pins after reset");
		fd = $fopen("verif/mk14_display_testdata.txt", "r");
		while ($fscanf(fd, "%s", tag) == 1) begin
			if (tag == "#") begin
				code = $fgets(line, fd);
			end else if (tag == "W") begin
				code = $fscanf(fd, "%h %h", a, d);
				write_byte(a, d);
				probe_random();
			end else if (tag == "B") begin
				code = $fscanf(fd, "%h", a);
				@(posedge clk);
				#2;
				brightness = tm1638_pkg::bright_t'(a);
			end else if (tag == "F") begin
				for (int i = 0; i < 8; i++) code = $fscanf(fd, "%h", exp_d[i]);
				code = $fscanf(fd, "%h", exp_b);
				t_mark = $time;
				while (done_start <= t_mark) @(frame_ev);
				for (int i = 0; i < 8; i++)
					check(32'(frame_buf[2 + 2 * i]), exp_d[i], $sformatf("digit %0d", i));
				check(32'(frame_buf[18]), 'h88 | exp_b, "brightness");
			end else begin
				$display("unknown record %s in the test data", tag);
				$display("** FAIL **");
				$fatal(1, "bad record");
			end
		end
		$fclose(fd);
		if (UUT.u_tx.u_assert.fail_cnt != 0) begin
			$display("transmitter assertions failed %0d times", UUT.u_tx.u_assert.fail_cnt);
			$display("** FAIL **");
			$fatal(1, "assertion failures");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end
end

endmodule

// ==== mk14_display.f ====
+incdir+verilog
verilog/mk14_mem_pkg.sv
verilog/tm1638_pkg.sv
verilog/bram_dp.sv
verilog/display_scanner.sv
verilog/tm1638_tx.sv
verilog/mk14_display_top.sv
verif/mk14_display_assert.sv
verif/mk14_display_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= mk14_display_tb
FLIST ?= mk14_display.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove build products"
	@echo "variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/mk14_display_testdata.txt ====
# W addr data | B brightness | F d0 d1 d2 d3 d4 d5 d6 d7 brightness
# all values in hex
B 2
W 100 3f
W 101 06
W 102 5b
W 103 4f
W 104 66
W 105 6d
W 106 7d
W 107 07
F 3f 06 5b 4f 66 6d 7d 07 2
B 5
F 3f 06 5b 4f 66 6d 7d 07 5
W 100 7f
W 104 71
W 107 80
F 7f 06 5b 4f 71 6d 7d 80 5
B 7
W 103 00
F 7f 06 5b 00 71 6d 7d 80 7
